//--- src/mem_params.svh
// Queue depth must be a power of two and stay below 2**MEM_TAG_W so live tags stay unique
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Pending queue slots
`define MEM_PMRQ_ENTRIES 8

// Tag carried by each request and response
`define MEM_TAG_W 7

// Word size and word address size (64 words)
`define MEM_DATA_W 32
`define MEM_ADDR_W 6

// Cycles from request to response per bank
`define MEM_BANK0_LAT 1   // Even addresses
`define MEM_BANK1_LAT 3   // Odd addresses

`endif

//--- src/lsu_pkg.sv
// Word accesses only; there are no byte enables, misaligned accesses or exceptions
`include "mem_params.svh"

package lsu_pkg;

    // Opcodes seen by the memory stage
    typedef enum logic [1:0] {
        OP_LOAD  = 2'b00,   // Read one word
        OP_STORE = 2'b01    // Write one word
    } mem_op_e;

    // Word address and word data
    typedef logic [`MEM_ADDR_W-1:0] word_addr_t;
    typedef logic [`MEM_DATA_W-1:0] word_data_t;

    // Instruction as it enters and leaves the stage
    typedef struct packed {
        mem_op_e    op;     // Load or store
        word_addr_t addr;   // Bank select sits in bit 0
        word_data_t data;   // Store data in, load data out
    } mem_instr_t;

endpackage

//--- src/mem_pkg.sv
// Responses may come back out of order; the tag is the only link to the request
`include "mem_params.svh"

package mem_pkg;

    // Bank select from address bit 0
    typedef enum logic {
        BANK0 = 1'b0,   // Even words with short latency
        BANK1 = 1'b1    // Odd words with long latency
    } bank_e;

    typedef struct packed {
        lsu_pkg::mem_op_e      op;
        lsu_pkg::word_addr_t   addr;
        lsu_pkg::word_data_t   data;    // Ignored for loads
        logic [`MEM_TAG_W-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_TAG_W-1:0] tag;
        lsu_pkg::word_data_t   data;    // Zero for stores
    } mem_rsp_t;

    // Which bank holds a word
    function automatic bank_e addr_bank(lsu_pkg::word_addr_t addr);
        return bank_e'(addr[0]);
    endfunction

endpackage

//--- src/mem_req_issue.sv
// Requests leave in the accept cycle; the memory must never stall and bank 1 latency is fixed
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_req_issue (
    input  logic                  clk_i,          // Core clock
    input  logic                  rstn_i,         // Async reset, active low
    input  logic                  flush_i,        // Restart tags at zero
    input  logic                  instr_valid_i,  // Issue stage offers an instruction
    input  lsu_pkg::mem_instr_t   instr_i,        // Load or store
    input  logic                  queue_full_i,   // No free slot in the pending queue
    output logic                  instr_ready_o,  // Instruction may transfer
    output logic                  req_valid_o,    // Request to memory this cycle
    output mem_pkg::mem_req_t     req_o,          // Request payload
    output logic [`MEM_TAG_W-1:0] alloc_tag_o     // Tag for the new queue entry
);

    logic [`MEM_TAG_W-1:0] tag_q;       // Next tag to hand out
    logic [1:0]            b1_hist_q;   // Bank 1 issues one and two cycles back
    mem_pkg::bank_e        instr_bank;
    logic                  collide;
    logic                  xfer;

    assign instr_bank = mem_pkg::addr_bank(instr_i.addr);

    // A bank 0 access now would respond together with the bank 1 access from two cycles ago
    assign collide = (instr_bank == mem_pkg::BANK0) && b1_hist_q[1];

    // Never looks at instr_valid_i
    assign instr_ready_o = ~queue_full_i & ~collide & ~flush_i;
    assign xfer          = instr_valid_i & instr_ready_o;

    // Request goes straight out
    assign req_valid_o = xfer;
    assign req_o.op    = instr_i.op;
    assign req_o.addr  = instr_i.addr;
    assign req_o.data  = instr_i.data;
    assign req_o.tag   = tag_q;
    assign alloc_tag_o = tag_q;        // Same tag lands in the queue

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tag_q     <= '0;
            b1_hist_q <= '0;
        end else begin
            // Keeps shifting across a flush since old bank 1 work still returns
            b1_hist_q <= {b1_hist_q[0], xfer & (instr_bank == mem_pkg::BANK1)};

            if (flush_i) begin
                tag_q <= '0;
            end else if (xfer) begin
                tag_q <= tag_q + 1'b1;   // Wraps around
            end
        end
    end

endmodule

//--- src/banked_data_mem.sv
// Always accepts; the requester must keep bank responses from landing in the same cycle
`timescale 1ns/1ps
`include "mem_params.svh"

module banked_data_mem (
    input  logic              clk_i,        // Core clock
    input  logic              rstn_i,       // Async reset, active low
    input  logic              req_valid_i,  // One request per cycle at most
    input  mem_pkg::mem_req_t req_i,        // Op, address, data and tag
    output logic              rsp_valid_o,  // Response this cycle
    output mem_pkg::mem_rsp_t rsp_o         // Tag and load data
);

    localparam int WORDS = 1 << `MEM_ADDR_W;

    logic [`MEM_DATA_W-1:0] mem_q [WORDS];  // Both banks share one array
    mem_pkg::bank_e         req_bank;
    logic                   is_store;
    mem_pkg::mem_rsp_t      new_rsp;        // Response formed in the request cycle
    logic [1:0]             bank_vld;       // Pipeline outputs per bank
    mem_pkg::mem_rsp_t      bank_rsp [2];

    assign req_bank     = mem_pkg::addr_bank(req_i.addr);
    assign is_store     = (req_i.op == lsu_pkg::OP_STORE);
    assign new_rsp.tag  = req_i.tag;
    assign new_rsp.data = is_store ? '0 : mem_q[req_i.addr];   // Read in the request cycle

    // Store writes at the end of its request cycle
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int w = 0; w < WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (req_valid_i && is_store) begin
            mem_q[req_i.addr] <= req_i.data;
        end
    end

    // Delay line per bank holding several requests in flight
    for (genvar b = 0; b < 2; b++) begin : g_bank
        localparam int LAT = (b == 0) ? `MEM_BANK0_LAT : `MEM_BANK1_LAT;

        logic [LAT-1:0]    vld_q;
        mem_pkg::mem_rsp_t rsp_q [LAT];
        logic              take;

        assign take = req_valid_i && (req_bank == mem_pkg::bank_e'(b));

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= take;
                for (int s = 1; s < LAT; s++) begin
                    vld_q[s] <= vld_q[s-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (take) rsp_q[0] <= new_rsp;    // Tag and data enter the first stage
            for (int s = 1; s < LAT; s++) begin
                rsp_q[s] <= rsp_q[s-1];
            end
        end

        assign bank_vld[b] = vld_q[LAT-1];
        assign bank_rsp[b] = rsp_q[LAT-1];
    end

    // At most one bank valid per cycle
    assign rsp_valid_o = |bank_vld;
    assign rsp_o       = bank_vld[1] ? bank_rsp[1] : bank_rsp[0];

endmodule

//--- src/pending_mem_req_queue.sv
// Full means every slot in use; depth must be a power of two and live tags must be unique
`timescale 1ns/1ps
`include "mem_params.svh"

module pending_mem_req_queue (
    input  logic                  clk_i,          // Core clock
    input  logic                  rstn_i,         // Async reset, active low
    input  logic                  flush_i,        // Drop every entry
    input  logic                  alloc_valid_i,  // New instruction at the tail
    input  lsu_pkg::mem_instr_t   instr_i,        // Instruction to hold
    input  logic [`MEM_TAG_W-1:0] tag_i,          // Its tag
    input  logic                  rsp_valid_i,    // Memory response this cycle
    input  mem_pkg::mem_rsp_t     rsp_i,          // Response tag and data
    input  logic                  wb_ready_i,     // Write-back takes the head
    output logic                  full_o,         // All slots used
    output logic                  wb_valid_o,     // Head is finished
    output lsu_pkg::mem_instr_t   wb_instr_o,     // Head instruction with result
    output logic [`MEM_TAG_W-1:0] wb_tag_o        // Head tag
);

    localparam int DEPTH = `MEM_PMRQ_ENTRIES;
    localparam int PTR_W = $clog2(DEPTH);

    logic [PTR_W-1:0]      head_q;              // Oldest entry
    logic [PTR_W-1:0]      tail_q;              // Next free entry
    logic [PTR_W:0]        count_q;             // Live entries, one bit wider
    lsu_pkg::mem_instr_t   instr_tbl [DEPTH];
    logic [`MEM_TAG_W-1:0] tag_tbl   [DEPTH];
    logic [DEPTH-1:0]      finish_q;            // Response seen
    logic [DEPTH-1:0]      valid_q;             // Entry live
    logic                  push;
    logic                  pop;
    logic [DEPTH-1:0]      hit;                 // Response matches this entry

    assign full_o = (count_q == (PTR_W + 1)'(DEPTH));
    assign push   = alloc_valid_i & ~full_o & ~flush_i;
    assign pop    = wb_valid_o & wb_ready_i;

    // Tag match only against live entries
    always_comb begin
        for (int j = 0; j < DEPTH; j++) begin
            hit[j] = rsp_valid_i & valid_q[j] & (tag_tbl[j] == rsp_i.tag);
        end
    end

    // Pointers and count
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) tail_q <= tail_q + 1'b1;   // Wraps with the power of two depth
            if (pop) head_q <= head_q + 1'b1;
            count_q <= count_q + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

    // Entry status bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q  <= '0;
            finish_q <= '0;
        end else if (flush_i) begin
            valid_q  <= '0;
            finish_q <= '0;
        end else begin
            finish_q <= finish_q | hit;
            if (pop) valid_q[head_q] <= 1'b0;
            if (push) begin
                valid_q[tail_q]  <= 1'b1;
                finish_q[tail_q] <= 1'b0;       // Fresh entry waits for its response
            end
        end
    end

    // Payload tables
    always_ff @(posedge clk_i) begin
        if (push) begin
            instr_tbl[tail_q] <= instr_i;
            tag_tbl[tail_q]   <= tag_i;
        end
        for (int j = 0; j < DEPTH; j++) begin
            if (hit[j]) begin
                // Loads keep memory data, stores report zero
                instr_tbl[j].data <= (instr_tbl[j].op == lsu_pkg::OP_LOAD) ? rsp_i.data : '0;
            end
        end
    end

    // Head waits here until taken
    assign wb_valid_o = valid_q[head_q] & finish_q[head_q];
    assign wb_instr_o = instr_tbl[head_q];
    assign wb_tag_o   = tag_tbl[head_q];

endmodule

//--- src/mem_unit_top.sv
// Memory stage with in-order write-back; instr_ready_o never depends on instr_valid_i
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_unit_top (
    input  logic                  clk_i,          // Core clock
    input  logic                  rstn_i,         // Async reset, active low
    input  logic                  flush_i,        // One cycle flush
    input  logic                  instr_valid_i,  // Issue side handshake
    input  lsu_pkg::mem_instr_t   instr_i,
    input  logic                  wb_ready_i,     // Write-back side handshake
    output logic                  instr_ready_o,
    output logic                  wb_valid_o,
    output lsu_pkg::mem_instr_t   wb_instr_o,
    output logic [`MEM_TAG_W-1:0] wb_tag_o
);

    logic                  queue_full;
    logic                  req_valid;   // Also the queue allocation strobe
    mem_pkg::mem_req_t     req;
    logic [`MEM_TAG_W-1:0] alloc_tag;
    logic                  rsp_valid;
    mem_pkg::mem_rsp_t     rsp;

    // Tags and collision stalls
    mem_req_issue i_issue (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .queue_full_i  (queue_full),
        .instr_ready_o (instr_ready_o),
        .req_valid_o   (req_valid),
        .req_o         (req),
        .alloc_tag_o   (alloc_tag)
    );

    banked_data_mem i_mem (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    // Reorders responses back into program order
    pending_mem_req_queue i_pmrq (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .alloc_valid_i (req_valid),
        .instr_i       (instr_i),
        .tag_i         (alloc_tag),
        .rsp_valid_i   (rsp_valid),
        .rsp_i         (rsp),
        .wb_ready_i    (wb_ready_i),
        .full_o        (queue_full),
        .wb_valid_o    (wb_valid_o),
        .wb_instr_o    (wb_instr_o),
        .wb_tag_o      (wb_tag_o)
    );

endmodule

//--- testbench/tb_mem_unit.sv
// Reads testbench/mem_unit_golden.txt relative to the project root; one instruction offered at a time
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_mem_unit;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  flush_i;
    logic                  instr_valid_i;
    lsu_pkg::mem_instr_t   instr_i;
    logic                  wb_ready_i;
    logic                  instr_ready_o;
    logic                  wb_valid_o;
    lsu_pkg::mem_instr_t   wb_instr_o;
    logic [`MEM_TAG_W-1:0] wb_tag_o;

    logic [135:0]          stim_q [$];      // Kind and four fields per stimulus line
    lsu_pkg::mem_instr_t   exp_instr_q [$]; // Expected write-backs in order
    logic [`MEM_TAG_W-1:0] exp_tag_q [$];
    int                    acc_cyc_q [$];   // Accept cycle of each issued instruction
    int                    exp_lat_q [$];   // Expected latency or 0 when not checked
    int                    cycle_cnt = 0;
    int                    acc_count = 0;
    int                    wb_count = 0;
    int                    hold_acc = 0;    // Accepted while write-back is held off
    int                    n_lines = 0;
    int                    wb_mode = 1;     // 0 held low, 1 high, 2 LFSR
    logic [15:0]           lfsr_q;
    logic                  loaded = 1'b0;

    mem_unit_top i_dut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_ready_i    (wb_ready_i),
        .instr_ready_o (instr_ready_o),
        .wb_valid_o    (wb_valid_o),
        .wb_instr_o    (wb_instr_o),
        .wb_tag_o      (wb_tag_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;   // 10 ns period
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // 16-bit Fibonacci LFSR with taps 16 14 13 11 shifting right
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    task automatic compare_instr(input lsu_pkg::mem_instr_t got, exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "instruction compare");
        end
    endtask

    task automatic compare_tag(input logic [`MEM_TAG_W-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "tag compare");
        end
    endtask

    task automatic compare_bit(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "flag compare");
        end
    endtask

    task automatic compare_count(input int got, exp, input string what);
        if (got != exp) begin
            $display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "count compare");
        end
    endtask

    // Entered and left just after a rising edge
    task automatic wait_idle();
        instr_valid_i = 1'b0;
        wb_mode       = 1;      // Drain with write-back always ready
        hold_acc      = 0;
        while (wb_count != acc_count) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // Holds the instruction until the DUT takes it and leaves valid high
    task automatic offer(input logic [31:0] op, addr, data, pat);
        logic done;
        done = 1'b0;
        if (pat == 3) wait_idle();                          // Alone in the unit
        else if (pat != 0 || wb_mode != 2) wb_mode = pat;   // Released hold stays on LFSR
        instr_valid_i = 1'b1;
        instr_i.op    = lsu_pkg::mem_op_e'(op[1:0]);
        instr_i.addr  = addr[`MEM_ADDR_W-1:0];
        instr_i.data  = data[`MEM_DATA_W-1:0];
        while (!done) begin
            @(negedge clk_i);
            if (instr_ready_o) begin
                done = 1'b1;
                acc_count++;
                if (pat == 0) hold_acc++;
                // Taken although every slot should already be in use
                if (pat == 0 && wb_mode == 0 && hold_acc > `MEM_PMRQ_ENTRIES) begin
                    compare_count(hold_acc, `MEM_PMRQ_ENTRIES,
                                  "instructions accepted before full");
                end
                acc_cyc_q.push_back(cycle_cnt);
                // Response latency plus one cycle to the head with the bank from address bit 0
                exp_lat_q.push_back(pat != 3 ? 0 :
                                    (addr[0] ? `MEM_BANK1_LAT : `MEM_BANK0_LAT) + 1);
            end else if (pat == 0 && wb_mode == 0) begin
                compare_count(hold_acc, `MEM_PMRQ_ENTRIES, "instructions accepted before full");
                wb_mode = 2;    // Let write-back drain at random
            end
            @(posedge clk_i);
            #1;
        end
    endtask

    // Write-back side drives wb_ready_i and checks each retirement
    initial begin
        int                    mode;
        int                    lat;
        int                    cyc;
        logic                  held;
        lsu_pkg::mem_instr_t   held_instr;
        logic [`MEM_TAG_W-1:0] held_tag;
        wb_ready_i = 1'b0;
        lfsr_q     = 16'd7;     // Seed
        held       = 1'b0;
        forever begin
            @(posedge clk_i);
            mode = wb_mode;
            #1;
            if (mode == 2) begin
                wb_ready_i = lfsr_q[0];          // One step per bit taken
                lfsr_q     = lfsr_next(lfsr_q);
            end else begin
                wb_ready_i = (mode == 1);
            end
            @(negedge clk_i);
            if (held) begin                      // Refused last cycle
                compare_bit(wb_valid_o, 1'b1, "wb_valid_o kept until accepted");
                compare_instr(wb_instr_o, held_instr, "payload steady under back-pressure");
                compare_tag(wb_tag_o, held_tag, "tag steady under back-pressure");
            end
            held       = wb_valid_o & ~wb_ready_i;
            held_instr = wb_instr_o;
            held_tag   = wb_tag_o;
            if (wb_valid_o && wb_ready_i) begin
                if (exp_tag_q.size() == 0) begin
                    $display("Error: write-back at %0t ns with no expected entry left", $time);
                    $display("Verification failed");
                    $fatal(1, "unexpected write-back");
                end else begin
                    compare_tag(wb_tag_o, exp_tag_q.pop_front(), "write-back tag");
                    compare_instr(wb_instr_o, exp_instr_q.pop_front(), "write-back payload");
                    lat = exp_lat_q.pop_front();
                    cyc = acc_cyc_q.pop_front();
                    if (lat != 0) compare_count(cycle_cnt - cyc, lat, "write-back latency");
                    wb_count++;
                end
            end
        end
    end

    // Limit scales with the golden file
    initial begin
        wait (loaded);
        repeat (n_lines * 20 + 200) @(posedge clk_i);
        $display("Error: the run did not finish within %0d cycles", n_lines * 20 + 200);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    initial begin
        int            fd;
        int            r;
        int            need;
        logic [7:0]    kind;
        logic [31:0]   f0, f1, f2, f3;
        logic [2047:0] rest;
        rstn_i        = 1'b0;
        flush_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        fd = $fopen("testbench/mem_unit_golden.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open testbench/mem_unit_golden.txt");
            $display("Verification failed");
            $fatal(1, "no golden file");
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            {f0, f1, f2, f3} = '0;
            need = 0;
            case (kind)
                "#": begin
                    need = 1;
                    r    = ($fgets(rest, fd) > 0);   // Rest of a comment line
                end
                "I", "E": begin
                    need = 4;
                    r    = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                end
                "N": begin
                    need = 1;
                    r    = $fscanf(fd, "%h", f0);
                end
                "W", "F": r = 0;
                default: begin
                    $display("Error: unknown line kind %s in the golden file", kind);
                    $display("Verification failed");
                    $fatal(1, "bad golden file");
                end
            endcase
            if (r != need) begin
                $display("Error: a line of kind %s in the golden file has too few fields", kind);
                $display("Verification failed");
                $fatal(1, "bad golden file");
            end
            if (kind != "#") n_lines++;
            if (kind == "E") begin
                exp_tag_q.push_back(f0[`MEM_TAG_W-1:0]);
                exp_instr_q.push_back({lsu_pkg::mem_op_e'(f1[1:0]), f2[`MEM_ADDR_W-1:0],
                                       f3[`MEM_DATA_W-1:0]});
            end else if (kind != "#") begin
                stim_q.push_back({kind, f0, f1, f2, f3});
            end
        end
        $fclose(fd);
        loaded = 1'b1;

        repeat (3) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        @(negedge clk_i);
        compare_bit(wb_valid_o, 1'b0, "wb_valid_o after reset");
        compare_bit(instr_ready_o, 1'b1, "instr_ready_o after reset");
        @(posedge clk_i);
        #1;

        foreach (stim_q[i]) begin
            {kind, f0, f1, f2, f3} = stim_q[i];
            if (kind == "I") begin
                offer(f0, f1, f2, f3);
            end else if (kind == "N") begin
                instr_valid_i = 1'b0;
                repeat (f0) begin
                    @(posedge clk_i);
                    #1;
                end
            end else begin
                wait_idle();
                if (kind == "F") begin
                    flush_i = 1'b1;
                    @(posedge clk_i);
                    #1;
                    flush_i = 1'b0;
                    @(negedge clk_i);
                    compare_bit(wb_valid_o, 1'b0, "wb_valid_o after flush");
                    compare_bit(instr_ready_o, 1'b1, "instr_ready_o after flush");
                    @(posedge clk_i);
                    #1;
                end
            end
        end

        wait_idle();
        repeat (5) @(posedge clk_i);      // Catch stray write-backs
        if (exp_tag_q.size() != 0) begin
            $display("Error: %0d expected write-backs never appeared", exp_tag_q.size());
            $display("Verification failed");
            $fatal(1, "missing write-backs");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- testbench/mem_unit_golden.txt
# I op addr data pat: op 0 load 1 store; pat 0 hold wb_ready low, 1 high, 3 alone with latency check
# E tag op addr data: next write-back in order; W wait idle; N n idle cycles; F idle flush
I 1 04 a5a50004 1
E 00 1 04 00000000
I 1 05 5a5a0005 1
E 01 1 05 00000000
I 0 04 00000000 3
E 02 0 04 a5a50004
I 0 05 00000000 3
E 03 0 05 5a5a0005
# Flush, then bank 1 before bank 0 and a collision two cycles apart
F
I 0 05 00000000 1
E 00 0 05 5a5a0005
I 0 04 00000000 1
E 01 0 04 a5a50004
I 0 07 00000000 1
E 02 0 07 00000000
N 1
I 0 04 00000000 1
E 03 0 04 a5a50004
# Nine offered with write-back held off, the ninth waits for a free slot
W
I 1 09 00000009 0
E 04 1 09 00000000
I 0 04 00000000 0
E 05 0 04 a5a50004
I 0 09 00000000 0
E 06 0 09 00000009
I 1 08 00000008 0
E 07 1 08 00000000
I 0 05 00000000 0
E 08 0 05 5a5a0005
I 0 08 00000000 0
E 09 0 08 00000008
I 0 07 00000000 0
E 0a 0 07 00000000
I 0 06 00000000 0
E 0b 0 06 00000000
I 0 09 00000000 0
E 0c 0 09 00000009

//--- build.f
+incdir+src
src/lsu_pkg.sv
src/mem_pkg.sv
src/mem_req_issue.sv
src/banked_data_mem.sv
src/pending_mem_req_queue.sv
src/mem_unit_top.sv
testbench/tb_mem_unit.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; a failing run exits nonzero through $fatal
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tb_mem_unit -o tb_mem_unit
./obj_dir/tb_mem_unit
